/* Makefile */
sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_y86 -f project.f
	@out="$$(./obj_dir/Vtb_y86)"; echo "$$out"; echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir

.PHONY: sim clean

/* hdl/y86_alu.sv */
`timescale 1ns/10ps

module y86_alu (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             commit,
  input  y86_pkg::fetch_t  fetch,
  input  y86_pkg::word_t   val_a,
  input  y86_pkg::word_t   val_b,
  output y86_pkg::word_t   val_e,
  output logic             cnd
);
  import y86_pkg::*;

  word_t   alu_a;
  word_t   alu_b;
  alu_fn_e alu_fn;
  logic    zf;
  logic    sf;
  logic    of;
  logic    of_next;

  always_comb
  begin
    alu_a  = '0;
    alu_b  = '0;
    alu_fn = ALU_ADD;
    case (fetch.icode)
      RRMOVQ:         alu_a = val_a;
      IRMOVQ:         alu_a = fetch.val_c;
      RMMOVQ, MRMOVQ:
      begin
        alu_a = fetch.val_c; // Displacement plus base.
        alu_b = val_b;
      end
      OPQ:
      begin
        alu_a  = val_a;
        alu_b  = val_b;
        alu_fn = alu_fn_e'(fetch.ifun);
      end
      default:        alu_a = '0;
    endcase
  end

  always_comb
  begin
    of_next = 1'b0;
    case (alu_fn)
      ALU_ADD:
      begin
        val_e   = alu_b + alu_a;
        of_next = (alu_a[63] == alu_b[63]) && (val_e[63] != alu_a[63]);
      end
      ALU_SUB:
      begin
        val_e   = alu_b - alu_a;
        of_next = (alu_a[63] != alu_b[63]) && (val_e[63] != alu_b[63]);
      end
      ALU_AND: val_e = alu_b & alu_a;
      ALU_XOR: val_e = alu_b ^ alu_a;
      default: val_e = '0;
    endcase
  end

  ////////////////////
  // Condition codes

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      zf <= 1'b1;
      sf <= 1'b0;
      of <= 1'b0;
    end
    else if (commit && fetch.icode == OPQ)
    begin
      zf <= (val_e == '0);
      sf <= val_e[63];
      of <= of_next;
    end
  end

  always_comb
  begin
    case (cond_e'(fetch.ifun))
      C_ALWAYS: cnd = 1'b1;
      C_LE:     cnd = (sf ^ of) | zf;
      C_L:      cnd = sf ^ of;
      C_E:      cnd = zf;
      C_NE:     cnd = !zf;
      C_GE:     cnd = !(sf ^ of);
      C_G:      cnd = !(sf ^ of) && !zf;
      default:  cnd = 1'b0;
    endcase
  end

endmodule

/* hdl/y86_data_mem.sv */
`timescale 1ns/10ps

module y86_data_mem (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             commit,
  input  y86_pkg::fetch_t  fetch,
  input  y86_pkg::word_t   addr,
  input  y86_pkg::word_t   val_a,
  output y86_pkg::word_t   val_m,
  output logic             mem_error
);
  import y86_pkg::*;

  logic [7:0] dmem [DMEM_BYTES];
  logic       is_mem;
  logic       wr_en;

  assign is_mem    = (fetch.icode == RMMOVQ) || (fetch.icode == MRMOVQ);
  assign mem_error = is_mem && (addr > word_t'(DMEM_BYTES - 8)); // Whole word must fit.
  assign wr_en     = commit && (fetch.icode == RMMOVQ) && !mem_error;

  // Little-endian word read.
  always_comb
  begin
    for (int i = 0; i < 8; i++)
    begin
      val_m[8*i +: 8] = dmem[addr[7:0] + 8'(i)];
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < DMEM_BYTES; i++)
      begin
        dmem[i] <= '0;
      end
    end
    else if (wr_en)
    begin
      for (int i = 0; i < 8; i++)
      begin
        dmem[addr[7:0] + 8'(i)] <= val_a[8*i +: 8];
      end
    end
  end

endmodule

/* hdl/y86_fetch.sv */
`timescale 1ns/10ps

module y86_fetch (
  input  logic                clk,
  input  logic                rst_n,
  input  y86_pkg::imem_load_t load,
  input  y86_pkg::word_t      pc,
  output y86_pkg::fetch_t     fetch
);
  import y86_pkg::*;

  logic [7:0] imem [IMEM_BYTES];
  logic [7:0] ibyte [10];
  logic [3:0] icode_raw;
  logic [3:0] ifun_raw;
  instr_u     instr;
  word_t      len;
  logic       known;

  always_ff @(posedge clk)
  begin
    if (load.valid)
      imem[load.addr] <= load.data;
  end

  ////////////////////
  // Instruction bytes

  always_comb
  begin
    for (int i = 0; i < 10; i++)
    begin
      ibyte[i] = imem[pc[7:0] + 8'(i)]; // Wraps, the range check below catches it.
    end
  end

  assign icode_raw = ibyte[0][7:4];
  assign ifun_raw  = ibyte[0][3:0];
  assign instr     = {8'h00, ibyte[9], ibyte[8], ibyte[7], ibyte[6], ibyte[5],
                      ibyte[4], ibyte[3], ibyte[2], ibyte[1]};

  ////////////////////
  // Decode

  always_comb
  begin
    known = 1'b1;
    len   = 64'd1;
    case (icode_raw)
      HALT, NOP:
        known = (ifun_raw == 4'h0);
      RRMOVQ:
      begin
        len   = 64'd2;
        known = (ifun_raw <= C_G);
      end
      OPQ:
      begin
        len   = 64'd2;
        known = (ifun_raw <= ALU_XOR);
      end
      IRMOVQ, RMMOVQ, MRMOVQ:
      begin
        len   = 64'd10;
        known = (ifun_raw == 4'h0);
      end
      JXX:
      begin
        len   = 64'd9;
        known = (ifun_raw <= C_G);
      end
      default:
        known = 1'b0;
    endcase
  end

  always_comb
  begin
    fetch.icode = icode_e'(icode_raw);
    fetch.ifun  = ifun_raw;
    fetch.ra    = REG_NONE;
    fetch.rb    = REG_NONE;
    fetch.val_c = '0;
    fetch.val_p = pc + len;
    if (icode_raw inside {RRMOVQ, OPQ, IRMOVQ, RMMOVQ, MRMOVQ})
    begin
      fetch.ra = instr.reg_view.ra;
      fetch.rb = instr.reg_view.rb;
    end
    if (icode_raw inside {IRMOVQ, RMMOVQ, MRMOVQ})
      fetch.val_c = instr.reg_view.val_c;
    else if (icode_raw == JXX)
      fetch.val_c = instr.dest_view.val_c; // Jump target sits right after the icode byte.

    if (!known)
      fetch.stat = INS;
    else if (pc > word_t'(IMEM_BYTES) - len)
      fetch.stat = ADR;
    else if (icode_raw == HALT)
      fetch.stat = HLT;
    else
      fetch.stat = AOK;
  end

  // The PC only moves on a commit, so a load beat must leave it alone.
  a_load_while_idle: assert property (@(posedge clk) disable iff (!rst_n)
    load.valid |=> $stable(pc))
    else $error("Instruction memory was loaded while the core was committing.");

endmodule

/* hdl/y86_pc_update.sv */
`timescale 1ns/10ps

module y86_pc_update (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              run,
  input  y86_pkg::fetch_t   fetch,
  input  logic              cnd,
  input  logic              mem_error,
  input  y86_pkg::word_t    val_e,
  input  y86_pkg::word_t    val_m,
  output logic              commit,
  output y86_pkg::word_t    pc,
  output y86_pkg::stat_e    stat,
  output y86_pkg::retire_t  retire
);
  import y86_pkg::*;

  logic  step;
  stat_e next_stat;
  word_t next_pc;

  assign step      = run && (stat == AOK); // An instruction retires this cycle.
  assign next_stat = (fetch.stat != AOK) ? fetch.stat : (mem_error ? ADR : AOK);
  assign commit    = step && (next_stat == AOK);
  assign next_pc   = (fetch.icode == JXX && cnd) ? fetch.val_c : fetch.val_p;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pc     <= '0;
      stat   <= AOK;
      retire <= '0;
    end
    else
    begin
      if (commit)
        pc <= next_pc;
      if (step)
        stat <= next_stat;
      retire.valid    <= step;
      retire.pc       <= pc;
      retire.icode    <= fetch.icode;
      retire.dst_e    <= commit ? dst_e_sel(fetch, cnd) : REG_NONE;
      retire.val_e    <= val_e;
      retire.dst_m    <= commit ? dst_m_sel(fetch) : REG_NONE;
      retire.val_m    <= val_m;
      retire.mem_wr   <= commit && (fetch.icode == RMMOVQ);
      retire.mem_addr <= val_e;
    end
  end

  // A halt stops the core without a commit.
  a_halt_stops: assert property (@(posedge clk) disable iff (!rst_n)
    step && (fetch.icode == HALT) |=> (stat != AOK) && !$past(commit))
    else $error("A halt instruction did not stop the core.");

endmodule

/* hdl/y86_pkg.sv */
package y86_pkg;

  ////////////////////
  // Words and sizes

  typedef logic [63:0] word_t;
  typedef logic [3:0]  reg_id_t;

  localparam reg_id_t REG_NONE   = 4'hf;
  localparam int      IMEM_BYTES = 256;
  localparam int      DMEM_BYTES = 256;

  ////////////////////
  // Encodings

  typedef enum logic [3:0] {
    HALT   = 4'h0,
    NOP    = 4'h1,
    RRMOVQ = 4'h2,
    IRMOVQ = 4'h3,
    RMMOVQ = 4'h4,
    MRMOVQ = 4'h5,
    OPQ    = 4'h6,
    JXX    = 4'h7
  } icode_e;

  typedef enum logic [3:0] {
    ALU_ADD = 4'h0,
    ALU_SUB = 4'h1,
    ALU_AND = 4'h2,
    ALU_XOR = 4'h3
  } alu_fn_e;

  typedef enum logic [3:0] {
    C_ALWAYS = 4'h0,
    C_LE     = 4'h1,
    C_L      = 4'h2,
    C_E      = 4'h3,
    C_NE     = 4'h4,
    C_GE     = 4'h5,
    C_G      = 4'h6
  } cond_e;

  typedef enum logic [1:0] {
    AOK = 2'd0,
    HLT = 2'd1,
    ADR = 2'd2,
    INS = 2'd3
  } stat_e;

  // Bytes 1..9 of an instruction, byte 1 in the low bits.
  typedef union packed {
    struct packed {
      logic [7:0] pad;
      word_t      val_c;
      reg_id_t    ra;
      reg_id_t    rb;
    } reg_view;
    struct packed {
      logic [15:0] pad;
      word_t       val_c;
    } dest_view;
  } instr_u;

  ////////////////////
  // Stage records

  typedef struct packed {
    icode_e     icode;
    logic [3:0] ifun;
    reg_id_t    ra;
    reg_id_t    rb;
    word_t      val_c;
    word_t      val_p;
    stat_e      stat;
  } fetch_t;

  typedef struct packed {
    logic       valid;
    logic [7:0] addr;
    logic [7:0] data;
  } imem_load_t;

  typedef struct packed {
    logic    valid;
    word_t   pc;
    icode_e  icode;
    reg_id_t dst_e;
    word_t   val_e;
    reg_id_t dst_m;
    word_t   val_m;
    logic    mem_wr;
    word_t   mem_addr;
  } retire_t;

  // Register that receives valE; a cmov with a false condition writes nothing.
  function automatic reg_id_t dst_e_sel(fetch_t f, logic cnd);
    case (f.icode)
      IRMOVQ, OPQ: return f.rb;
      RRMOVQ:      return cnd ? f.rb : REG_NONE;
      default:     return REG_NONE;
    endcase
  endfunction

  function automatic reg_id_t dst_m_sel(fetch_t f);
    return (f.icode == MRMOVQ) ? f.ra : REG_NONE;
  endfunction

endpackage

/* hdl/y86_regfile.sv */
`timescale 1ns/10ps

module y86_regfile (
  input  logic             clk,
  input  logic             rst_n,
  input  y86_pkg::fetch_t  fetch,
  input  logic             commit,
  input  logic             cnd,
  input  y86_pkg::word_t   val_e,
  input  y86_pkg::word_t   val_m,
  output y86_pkg::word_t   val_a,
  output y86_pkg::word_t   val_b
);
  import y86_pkg::*;

  word_t   regs [15];
  reg_id_t src_a;
  reg_id_t src_b;
  reg_id_t dst_e;
  reg_id_t dst_m;

  ////////////////////
  // Read side

  always_comb
  begin
    src_a = REG_NONE;
    src_b = REG_NONE;
    case (fetch.icode)
      RRMOVQ, RMMOVQ, OPQ:
      begin
        src_a = fetch.ra;
        src_b = fetch.rb;
      end
      MRMOVQ:
        src_b = fetch.rb; // Base register of the address.
      default:
      begin
        src_a = REG_NONE;
        src_b = REG_NONE;
      end
    endcase
  end

  assign val_a = (src_a == REG_NONE) ? '0 : regs[src_a];
  assign val_b = (src_b == REG_NONE) ? '0 : regs[src_b];

  ////////////////////
  // Write side

  assign dst_e = dst_e_sel(fetch, cnd);
  assign dst_m = dst_m_sel(fetch);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < 15; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (commit)
    begin
      if (dst_e != REG_NONE)
        regs[dst_e] <= val_e;
      if (dst_m != REG_NONE)
        regs[dst_m] <= val_m; // Load result, never together with valE here.
    end
  end

  a_no_reg15_write: assert property (@(posedge clk) disable iff (!rst_n)
    commit && (fetch.icode inside {IRMOVQ, OPQ, MRMOVQ})
      |-> ((fetch.icode == MRMOVQ) ? fetch.ra : fetch.rb) != REG_NONE)
    else $error("Committed instruction names register 15 as its destination.");

endmodule

/* hdl/y86_seq_core.sv */
`timescale 1ns/10ps

module y86_seq_core (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                run,
  input  y86_pkg::imem_load_t load,
  output y86_pkg::stat_e      stat,
  output y86_pkg::retire_t    retire
);
  import y86_pkg::*;

  fetch_t fetch;
  word_t  pc;
  word_t  val_a;
  word_t  val_b;
  word_t  val_e;
  word_t  val_m;
  logic   commit;
  logic   cnd;
  logic   mem_error;

  y86_fetch fetch_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .load  (load),
    .pc    (pc),
    .fetch (fetch)
  );

  y86_regfile regfile_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .fetch  (fetch),
    .commit (commit),
    .cnd    (cnd),
    .val_e  (val_e),
    .val_m  (val_m),
    .val_a  (val_a),
    .val_b  (val_b)
  );

  y86_alu alu_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .commit (commit),
    .fetch  (fetch),
    .val_a  (val_a),
    .val_b  (val_b),
    .val_e  (val_e),
    .cnd    (cnd)
  );

  y86_data_mem data_mem_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .commit    (commit),
    .fetch     (fetch),
    .addr      (val_e), // Effective address from the ALU.
    .val_a     (val_a),
    .val_m     (val_m),
    .mem_error (mem_error)
  );

  y86_pc_update pc_update_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .run       (run),
    .fetch     (fetch),
    .cnd       (cnd),
    .mem_error (mem_error),
    .val_e     (val_e),
    .val_m     (val_m),
    .commit    (commit),
    .pc        (pc),
    .stat      (stat),
    .retire    (retire)
  );

endmodule

/* project.f */
hdl/y86_pkg.sv
hdl/y86_fetch.sv
hdl/y86_regfile.sv
hdl/y86_alu.sv
hdl/y86_data_mem.sv
hdl/y86_pc_update.sv
hdl/y86_seq_core.sv
tests/y86_checker.sv
tests/tb_y86.sv

/* tests/tb_y86.sv */
`timescale 1ns/10ps

module tb_y86;
  import y86_pkg::*;

  localparam int NUM_CASES   = 5;
  localparam int MAX_BYTES   = 64;
  localparam int MAX_RETIRES = 16;

  logic       clk;
  logic       rst_n;
  logic       run;
  imem_load_t load;
  stat_e      stat;
  retire_t    retire;

  logic [7:0] prog_tab [NUM_CASES][MAX_BYTES];
  int         prog_len [NUM_CASES];
  retire_t    exp_tab  [NUM_CASES][MAX_RETIRES];
  int         exp_len  [NUM_CASES];
  stat_e      stat_tab [NUM_CASES];
  int         cur;

  retire_t    cur_exp [MAX_RETIRES]; // Expectations of the running case.
  int         cur_len;
  stat_e      cur_stat;
  logic       case_done;
  logic       table_ready;
  int         watchdog_cycles;
  int         value_errs;
  int         seq_errs;

  y86_seq_core y86_seq_core_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .run    (run),
    .load   (load),
    .stat   (stat),
    .retire (retire)
  );

  y86_checker checker_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .run        (run),
    .stat       (stat),
    .retire     (retire),
    .exp_list   (cur_exp),
    .exp_len    (cur_len),
    .exp_stat   (cur_stat),
    .case_done  (case_done),
    .value_errs (value_errs),
    .seq_errs   (seq_errs)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////
  // Program and expectation builders

  task automatic emit_byte(input logic [7:0] b);
    prog_tab[cur][prog_len[cur]] = b;
    prog_len[cur]++;
  endtask

  task automatic emit_word(input word_t w);
    for (int i = 0; i < 8; i++)
    begin
      emit_byte(w[8*i +: 8]); // Little-endian.
    end
  endtask

  task automatic emit_rr(input logic [7:0] op, input reg_id_t ra, input reg_id_t rb);
    emit_byte(op);
    emit_byte({ra, rb});
  endtask

  task automatic emit_rrc(input logic [7:0] op, input reg_id_t ra, input reg_id_t rb,
                          input word_t c);
    emit_rr(op, ra, rb);
    emit_word(c);
  endtask

  task automatic emit_jump(input logic [7:0] op, input word_t dest);
    emit_byte(op);
    emit_word(dest);
  endtask

  task automatic expect_retire(input word_t pc, input icode_e icode, input reg_id_t dst_e,
                               input word_t val_e, input reg_id_t dst_m, input word_t val_m,
                               input logic mem_wr, input word_t mem_addr);
    exp_tab[cur][exp_len[cur]] = {1'b1, pc, icode, dst_e, val_e, dst_m, val_m, mem_wr, mem_addr};
    exp_len[cur]++;
  endtask

  task automatic expect_write(input word_t pc, input icode_e icode, input reg_id_t dst,
                              input word_t val);
    expect_retire(pc, icode, dst, val, REG_NONE, '0, 1'b0, '0);
  endtask

  task automatic expect_plain(input word_t pc, input icode_e icode);
    expect_retire(pc, icode, REG_NONE, '0, REG_NONE, '0, 1'b0, '0);
  endtask

  task automatic build_table();
    word_t a;
    word_t b;
    word_t c;
    word_t v;
    for (int n = 0; n < NUM_CASES; n++)
    begin
      prog_len[n] = 0;
      exp_len[n]  = 0;
    end
    a = 64'hffff_ffff_ffff_fff0;
    b = 64'h0000_0000_0000_0025;
    c = 64'h0123_4567_89ab_cdef;
    v = 64'hdead_beef_0bad_f00d;

    cur = 0; // Arithmetic where the add wraps around.
    emit_rrc(8'h30, REG_NONE, 4'h0, a);
    emit_rrc(8'h30, REG_NONE, 4'h3, b);
    emit_rrc(8'h30, REG_NONE, 4'h1, c);
    emit_rr(8'h60, 4'h0, 4'h3);
    emit_rr(8'h61, 4'h1, 4'h0);
    emit_rr(8'h62, 4'h3, 4'h1);
    emit_rr(8'h63, 4'h0, 4'h1);
    emit_byte(8'h00);
    expect_write(0, IRMOVQ, 4'h0, a);
    expect_write(10, IRMOVQ, 4'h3, b);
    expect_write(20, IRMOVQ, 4'h1, c);
    expect_write(30, OPQ, 4'h3, b + a);
    expect_write(32, OPQ, 4'h0, a - c);
    expect_write(34, OPQ, 4'h1, c & (b + a));
    expect_write(36, OPQ, 4'h1, (c & (b + a)) ^ (a - c));
    expect_plain(38, HALT);
    stat_tab[0] = HLT;

    cur = 1; // Conditional moves and jumps after a nonzero result.
    emit_rrc(8'h30, REG_NONE, 4'h0, 64'd5);
    emit_rrc(8'h30, REG_NONE, 4'h2, 64'd8);
    emit_rr(8'h61, 4'h0, 4'h2);
    emit_rr(8'h24, 4'h0, 4'h6);
    emit_rr(8'h23, 4'h0, 4'h7);
    emit_jump(8'h73, 64'h30);
    emit_jump(8'h74, 64'd46);
    emit_byte(8'hc0); // Skipped by the taken jump.
    emit_byte(8'hc0);
    emit_rr(8'h20, 4'h6, 4'h3);
    emit_byte(8'h00);
    expect_write(0, IRMOVQ, 4'h0, 64'd5);
    expect_write(10, IRMOVQ, 4'h2, 64'd8);
    expect_write(20, OPQ, 4'h2, 64'd8 - 64'd5);
    expect_write(22, RRMOVQ, 4'h6, 64'd5);
    expect_plain(24, RRMOVQ);
    expect_plain(26, JXX);
    expect_plain(35, JXX);
    expect_write(46, RRMOVQ, 4'h3, 64'd5);
    expect_plain(48, HALT);
    stat_tab[1] = HLT;

    cur = 2; // Store then load at base plus offset.
    emit_rrc(8'h30, REG_NONE, 4'h3, 64'h40);
    emit_rrc(8'h30, REG_NONE, 4'h0, v);
    emit_rrc(8'h40, 4'h0, 4'h3, 64'h18);
    emit_rrc(8'h50, 4'h1, 4'h3, 64'h18);
    emit_byte(8'h00);
    expect_write(0, IRMOVQ, 4'h3, 64'h40);
    expect_write(10, IRMOVQ, 4'h0, v);
    expect_retire(20, RMMOVQ, REG_NONE, '0, REG_NONE, '0, 1'b1, 64'h40 + 64'h18);
    expect_retire(30, MRMOVQ, REG_NONE, '0, 4'h1, v, 1'b0, '0);
    expect_plain(40, HALT);
    stat_tab[2] = HLT;

    cur = 3;
    emit_rrc(8'h30, REG_NONE, 4'h0, 64'd7);
    emit_byte(8'hc0);
    expect_write(0, IRMOVQ, 4'h0, 64'd7);
    expect_plain(10, icode_e'(4'hc));
    stat_tab[3] = INS;

    cur = 4; // Load word at 250 runs past the data memory.
    emit_rrc(8'h30, REG_NONE, 4'h3, 64'd250);
    emit_rrc(8'h50, 4'h0, 4'h3, 64'd0);
    emit_byte(8'h00);
    expect_write(0, IRMOVQ, 4'h3, 64'd250);
    expect_plain(10, MRMOVQ);
    stat_tab[4] = ADR;
  endtask

  ////////////////////
  // Stimulus

  task automatic run_case(input int n);
    int idle;
    for (int i = 0; i < MAX_RETIRES; i++)
    begin
      cur_exp[i] = exp_tab[n][i];
    end
    cur_len  = exp_len[n];
    cur_stat = stat_tab[n];
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < prog_len[n]; i++)
    begin
      @(posedge clk);
      load <= {1'b1, 8'(i), prog_tab[n][i]};
    end
    @(posedge clk);
    load <= '0;
    repeat (2) @(posedge clk);
    run <= 1'b1;
    repeat (2) @(posedge clk);
    idle = $urandom_range(4, 1);
    run <= 1'b0; // Pause in the middle of the program.
    repeat (idle) @(posedge clk);
    run <= 1'b1;
    while (stat == AOK)
      @(negedge clk);
    repeat (4) @(posedge clk);
    case_done <= 1'b1;
    @(posedge clk);
    case_done <= 1'b0;
    run       <= 1'b0;
  endtask

  initial
  begin
    rst_n       = 1'b0;
    run         = 1'b0;
    load        = '0;
    case_done   = 1'b0;
    table_ready = 1'b0;
    cur_len     = 0;
    cur_stat    = AOK;
    for (int i = 0; i < MAX_RETIRES; i++)
    begin
      cur_exp[i] = '0;
    end
    void'($urandom(32'h27aa));
    build_table();
    watchdog_cycles = 0;
    for (int n = 0; n < NUM_CASES; n++)
    begin
      watchdog_cycles += prog_len[n] * 4 + 32; // Reset, load and tail per case.
    end
    table_ready = 1'b1;
    for (int n = 0; n < NUM_CASES; n++)
    begin
      run_case(n);
    end
    @(posedge clk);
    $display("Errors: %0d value mismatches, %0d sequence errors", value_errs, seq_errs);
    if (value_errs == 0 && seq_errs == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

  initial
  begin
    wait (table_ready);
    repeat (watchdog_cycles) @(posedge clk);
    $display("Watchdog expired after %0d cycles before the last test case finished.",
             watchdog_cycles);
    $display("Regression failed");
    $finish;
  end

endmodule

/* tests/y86_checker.sv */
`timescale 1ns/10ps

module y86_checker (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             run,
  input  y86_pkg::stat_e   stat,
  input  y86_pkg::retire_t retire,
  input  y86_pkg::retire_t exp_list [16],
  input  int               exp_len,
  input  y86_pkg::stat_e   exp_stat,
  input  logic             case_done,
  output int               value_errs,
  output int               seq_errs
);
  import y86_pkg::*;

  int   value_count = 0;
  int   seq_count   = 0;
  int   idx         = 0;
  logic started     = 1'b0;
  logic run_prev    = 1'b0;

  assign value_errs = value_count;
  assign seq_errs   = seq_count;

  task automatic check_word(input string name, input word_t expected, input word_t got);
    if (expected !== got)
    begin
      value_count++;
      $display("Error %0t %s expected %h got %h", $time, name, expected, got);
    end
  endtask

  // Values only matter where the instruction really wrote something.
  task automatic compare_retire(input retire_t e);
    check_word("retire.pc", e.pc, retire.pc);
    check_word("retire.icode", word_t'(e.icode), word_t'(retire.icode));
    check_word("retire.dst_e", word_t'(e.dst_e), word_t'(retire.dst_e));
    if (e.dst_e != REG_NONE)
      check_word("retire.val_e", e.val_e, retire.val_e);
    check_word("retire.dst_m", word_t'(e.dst_m), word_t'(retire.dst_m));
    if (e.dst_m != REG_NONE)
      check_word("retire.val_m", e.val_m, retire.val_m);
    check_word("retire.mem_wr", word_t'(e.mem_wr), word_t'(retire.mem_wr));
    if (e.mem_wr)
      check_word("retire.mem_addr", e.mem_addr, retire.mem_addr);
  endtask

  ////////////////////
  // Sampled on the falling edge, half a cycle after the core updates.

  always @(negedge clk)
  begin
    if (!rst_n)
    begin
      idx      = 0;
      started  = 1'b0;
      run_prev = 1'b0;
    end
    else
    begin
      if (!started)
        check_word("stat", word_t'(AOK), word_t'(stat)); // Idle after reset.
      if (retire.valid)
      begin
        if (!run_prev)
        begin
          seq_count++;
          $display("A retire appeared at %0t after a cycle with run low.", $time);
        end
        else if (idx >= exp_len)
        begin
          seq_count++;
          $display("An extra retire for pc %0h appeared at %0t, only %0d were expected.",
                   retire.pc, $time, exp_len);
        end
        else
          compare_retire(exp_list[idx]);
        idx++;
      end
      if (case_done)
      begin
        if (idx < exp_len)
        begin
          seq_count++;
          $display("Only %0d of %0d expected retires appeared before %0t.", idx, exp_len, $time);
        end
        check_word("stat", word_t'(exp_stat), word_t'(stat));
      end
      if (run)
        started = 1'b1;
      run_prev = run;
    end
  end

endmodule
